// File: source/vec_settings.svh
// ------------------------------------------------------------------------
// Vector datapath settings
// Register count, address width, word width and lane counts
// ------------------------------------------------------------------------

`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

// Register file geometry
`define VEC_NUM_REGS  32
`define VEC_ADDR_W    5

// Word width and lane split
`define VEC_DATA_W    128
`define VEC_NUM_BYTES 16
`define VEC_NUM_WORDS 4

`endif

// File: source/vec_pkg.sv
// ------------------------------------------------------------------------
// Vector datapath package
// Data word views, operation codes and write requester names
// ------------------------------------------------------------------------

`default_nettype none

`include "vec_settings.svh"

package vec_pkg;

    // One 128-bit word, seen as byte lanes or as 32-bit lanes
    typedef union packed {
        logic [`VEC_NUM_BYTES-1:0][7:0]  bytes;
        logic [`VEC_NUM_WORDS-1:0][31:0] words;
    } vec_data_t;

    // Execute unit operations
    typedef enum logic [2:0] {
        ADD8  = 3'd0,
        ADD32 = 3'd1,
        SUB32 = 3'd2,
        AND   = 3'd3,
        XOR   = 3'd4,
        STORE = 3'd5
    } vec_op_t;

    // Peers sharing the register file write port
    typedef enum logic {
        EXEC = 1'b0,
        LOAD = 1'b1
    } vec_src_t;

endpackage

`default_nettype wire

// File: source/vec_rf.sv
// ------------------------------------------------------------------------
// Vector register file
// 32 x 128-bit words, byte-enable write, two combinational read ports
// ------------------------------------------------------------------------

`default_nettype none

`include "vec_settings.svh"

module vec_rf
    import vec_pkg::*;
(
    input  logic                      clk,

    // Write port
    input  logic [`VEC_NUM_BYTES-1:0] wr_en,
    input  logic [`VEC_ADDR_W-1:0]    wr_addr,
    input  vec_data_t                 wr_data,

    // Read ports
    input  logic [`VEC_ADDR_W-1:0]    rd_addr_a,
    input  logic [`VEC_ADDR_W-1:0]    rd_addr_b,
    output vec_data_t                 rd_data_a,
    output vec_data_t                 rd_data_b
);

    // Storage array
    vec_data_t regs [`VEC_NUM_REGS];

    // Byte-masked write
    always_ff @(posedge clk) begin
        for (int i = 0; i < `VEC_NUM_BYTES; i++) begin
            if (wr_en[i]) begin
                regs[wr_addr].bytes[i] <= wr_data.bytes[i];
            end
        end
    end

    // Asynchronous reads, no write bypass
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// File: source/vec_exec_unit.sv
// ------------------------------------------------------------------------
// Vector execute unit
// Lane-wise ALU with write-back request, and the store output path
// ------------------------------------------------------------------------

`default_nettype none

`include "vec_settings.svh"

module vec_exec_unit
    import vec_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // Operation strobe
    input  logic                   op_valid,
    input  vec_op_t                op_code,
    input  logic [`VEC_ADDR_W-1:0] op_vd,
    input  logic [`VEC_ADDR_W-1:0] op_vs1,
    input  logic [`VEC_ADDR_W-1:0] op_vs2,

    // Register file reads
    output logic [`VEC_ADDR_W-1:0] rd_addr_a,
    output logic [`VEC_ADDR_W-1:0] rd_addr_b,
    input  vec_data_t              rd_data_a,
    input  vec_data_t              rd_data_b,

    // Write-back request, full mask implied
    output logic                   exec_wr_valid,
    output logic [`VEC_ADDR_W-1:0] exec_wr_addr,
    output vec_data_t              exec_wr_data,

    // Store output
    output logic                   store_valid,
    output vec_data_t              store_data
);

    logic                   cmd_valid;
    vec_op_t                cmd_op;
    logic [`VEC_ADDR_W-1:0] cmd_vd;
    logic [`VEC_ADDR_W-1:0] cmd_vs1;
    logic [`VEC_ADDR_W-1:0] cmd_vs2;
    vec_data_t              alu_res;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= op_valid;
        end
    end

    // Command held until the next strobe
    always_ff @(posedge clk) begin
        if (op_valid) begin
            cmd_op  <= op_code;
            cmd_vd  <= op_vd;
            cmd_vs1 <= op_vs1;
            cmd_vs2 <= op_vs2;
        end
    end

    assign rd_addr_a = cmd_vs1;
    assign rd_addr_b = cmd_vs2;

    // Lane arithmetic wraps inside each lane
    always_comb begin
        alu_res = '0;
        case (cmd_op)
            ADD8: begin
                for (int i = 0; i < `VEC_NUM_BYTES; i++) begin
                    alu_res.bytes[i] = rd_data_a.bytes[i] + rd_data_b.bytes[i];
                end
            end
            ADD32: begin
                for (int i = 0; i < `VEC_NUM_WORDS; i++) begin
                    alu_res.words[i] = rd_data_a.words[i] + rd_data_b.words[i];
                end
            end
            SUB32: begin
                for (int i = 0; i < `VEC_NUM_WORDS; i++) begin
                    alu_res.words[i] = rd_data_a.words[i] - rd_data_b.words[i];
                end
            end
            AND:     alu_res = rd_data_a & rd_data_b;
            XOR:     alu_res = rd_data_a ^ rd_data_b;
            default: alu_res = '0;
        endcase
    end

    assign exec_wr_valid = cmd_valid && (cmd_op != STORE);
    assign exec_wr_addr  = cmd_vd;
    assign exec_wr_data  = alu_res;

    // Store returns the vs1 word in the cycle after the strobe
    assign store_valid = cmd_valid && (cmd_op == STORE);
    assign store_data  = rd_data_a;

    a_op_defined: assert property (
        @(posedge clk) disable iff (!rst_n)
        op_valid |-> (op_code inside {ADD8, ADD32, SUB32, AND, XOR, STORE})
    ) else $error("undefined op_code %0d", op_code);

endmodule

`default_nettype wire

// File: source/vec_load_unit.sv
// ------------------------------------------------------------------------
// Vector load unit
// Registers external loads into one byte-masked write request
// ------------------------------------------------------------------------

`default_nettype none

`include "vec_settings.svh"

module vec_load_unit
    import vec_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    // External load strobe
    input  logic                      load_valid,
    input  logic [`VEC_ADDR_W-1:0]    load_addr,
    input  vec_data_t                 load_data,
    input  logic [`VEC_NUM_BYTES-1:0] load_mask,

    // Write request towards the arbiter
    output logic                      load_wr_valid,
    output logic [`VEC_ADDR_W-1:0]    load_wr_addr,
    output vec_data_t                 load_wr_data,
    output logic [`VEC_NUM_BYTES-1:0] load_wr_mask
);

    logic mask_any;

    // Empty mask would write nothing
    assign mask_any = |load_mask;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_wr_valid <= 1'b0;
        end else begin
            load_wr_valid <= load_valid && mask_any;
        end
    end

    // Payload captured on every strobe
    always_ff @(posedge clk) begin
        if (load_valid) begin
            load_wr_addr <= load_addr;
            load_wr_data <= load_data;
            load_wr_mask <= load_mask;
        end
    end

endmodule

`default_nettype wire

// File: source/vec_wr_arbiter.sv
// ------------------------------------------------------------------------
// Register file write arbiter
// One buffered slot per peer, alternating grant when both are full
// ------------------------------------------------------------------------

`default_nettype none

`include "vec_settings.svh"

module vec_wr_arbiter
    import vec_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    // Execute unit request
    input  logic                      exec_wr_valid,
    input  logic [`VEC_ADDR_W-1:0]    exec_wr_addr,
    input  vec_data_t                 exec_wr_data,

    // Load unit request
    input  logic                      load_wr_valid,
    input  logic [`VEC_ADDR_W-1:0]    load_wr_addr,
    input  vec_data_t                 load_wr_data,
    input  logic [`VEC_NUM_BYTES-1:0] load_wr_mask,

    // Register file write port
    output logic [`VEC_NUM_BYTES-1:0] wr_en,
    output logic [`VEC_ADDR_W-1:0]    wr_addr,
    output vec_data_t                 wr_data
);

    logic                      exec_full;
    logic [`VEC_ADDR_W-1:0]    exec_addr_q;
    vec_data_t                 exec_data_q;

    logic                      load_full;
    logic [`VEC_ADDR_W-1:0]    load_addr_q;
    vec_data_t                 load_data_q;
    logic [`VEC_NUM_BYTES-1:0] load_mask_q;

    vec_src_t                  last_win;
    logic                      grant_exec;
    logic                      grant_load;

    // Sole full slot wins, otherwise the one that lost last time
    assign grant_exec = exec_full && (!load_full || last_win == LOAD);
    assign grant_load = load_full && (!exec_full || last_win == EXEC);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exec_full <= 1'b0;
            load_full <= 1'b0;
            last_win  <= LOAD;
        end else begin
            if (exec_wr_valid) begin
                exec_full <= 1'b1;
            end else if (grant_exec) begin
                exec_full <= 1'b0;
            end

            if (load_wr_valid) begin
                load_full <= 1'b1;
            end else if (grant_load) begin
                load_full <= 1'b0;
            end

            if (grant_exec) begin
                last_win <= EXEC;
            end else if (grant_load) begin
                last_win <= LOAD;
            end
        end
    end

    // Slot payloads
    always_ff @(posedge clk) begin
        if (exec_wr_valid) begin
            exec_addr_q <= exec_wr_addr;
            exec_data_q <= exec_wr_data;
        end
        if (load_wr_valid) begin
            load_addr_q <= load_wr_addr;
            load_data_q <= load_wr_data;
            load_mask_q <= load_wr_mask;
        end
    end

    // Execute results always write the whole word
    always_comb begin
        wr_en   = '0;
        wr_addr = exec_addr_q;
        wr_data = exec_data_q;
        if (grant_exec) begin
            wr_en = '1;
        end else if (grant_load) begin
            wr_en   = load_mask_q;
            wr_addr = load_addr_q;
            wr_data = load_data_q;
        end
    end

    // Also catches a peer requesting on consecutive cycles
    a_exec_no_overrun: assert property (
        @(posedge clk) disable iff (!rst_n)
        exec_wr_valid |-> !exec_full
    ) else $error("exec request into full slot");

    a_load_no_overrun: assert property (
        @(posedge clk) disable iff (!rst_n)
        load_wr_valid |-> !load_full
    ) else $error("load request into full slot");

endmodule

`default_nettype wire

// File: source/vec_core_top.sv
// ------------------------------------------------------------------------
// Vector core top level
// Execute and load units sharing the register file through the arbiter
// ------------------------------------------------------------------------

`default_nettype none

`include "vec_settings.svh"

module vec_core_top
    import vec_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    // Load port
    input  logic                      load_valid,
    input  logic [`VEC_ADDR_W-1:0]    load_addr,
    input  vec_data_t                 load_data,
    input  logic [`VEC_NUM_BYTES-1:0] load_mask,

    // Operation port
    input  logic                      op_valid,
    input  vec_op_t                   op_code,
    input  logic [`VEC_ADDR_W-1:0]    op_vd,
    input  logic [`VEC_ADDR_W-1:0]    op_vs1,
    input  logic [`VEC_ADDR_W-1:0]    op_vs2,

    // Store output
    output logic                      store_valid,
    output vec_data_t                 store_data
);

    logic [`VEC_ADDR_W-1:0]    rd_addr_a;
    logic [`VEC_ADDR_W-1:0]    rd_addr_b;
    vec_data_t                 rd_data_a;
    vec_data_t                 rd_data_b;

    logic                      exec_wr_valid;
    logic [`VEC_ADDR_W-1:0]    exec_wr_addr;
    vec_data_t                 exec_wr_data;

    logic                      load_wr_valid;
    logic [`VEC_ADDR_W-1:0]    load_wr_addr;
    vec_data_t                 load_wr_data;
    logic [`VEC_NUM_BYTES-1:0] load_wr_mask;

    logic [`VEC_NUM_BYTES-1:0] wr_en;
    logic [`VEC_ADDR_W-1:0]    wr_addr;
    vec_data_t                 wr_data;

    vec_exec_unit u_exec (
        .clk           (clk),
        .rst_n         (rst_n),
        .op_valid      (op_valid),
        .op_code       (op_code),
        .op_vd         (op_vd),
        .op_vs1        (op_vs1),
        .op_vs2        (op_vs2),
        .rd_addr_a     (rd_addr_a),
        .rd_addr_b     (rd_addr_b),
        .rd_data_a     (rd_data_a),
        .rd_data_b     (rd_data_b),
        .exec_wr_valid (exec_wr_valid),
        .exec_wr_addr  (exec_wr_addr),
        .exec_wr_data  (exec_wr_data),
        .store_valid   (store_valid),
        .store_data    (store_data)
    );

    vec_load_unit u_load (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_valid    (load_valid),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .load_mask     (load_mask),
        .load_wr_valid (load_wr_valid),
        .load_wr_addr  (load_wr_addr),
        .load_wr_data  (load_wr_data),
        .load_wr_mask  (load_wr_mask)
    );

    vec_wr_arbiter u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .exec_wr_valid (exec_wr_valid),
        .exec_wr_addr  (exec_wr_addr),
        .exec_wr_data  (exec_wr_data),
        .load_wr_valid (load_wr_valid),
        .load_wr_addr  (load_wr_addr),
        .load_wr_data  (load_wr_data),
        .load_wr_mask  (load_wr_mask),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data)
    );

    vec_rf u_rf (
        .clk       (clk),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

endmodule

`default_nettype wire

// File: sim/vec_checker.sv
// ------------------------------------------------------------------------
// Store output checker
// Compares each store word with the expected word queued by the testbench
// ------------------------------------------------------------------------

`default_nettype none

`include "vec_settings.svh"

module vec_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   store_valid,
    input logic [`VEC_DATA_W-1:0] store_data
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [`VEC_DATA_W-1:0] exp_q [$];
    int                     test_count  = 0;
    int                     check_count = 0;
    int                     error_count = 0;
    int                     test_checks = 0;
    int                     test_errors = 0;
    int                     wait_cycles = 0;

    task automatic push_expected(input logic [`VEC_DATA_W-1:0] word);
        exp_q.push_back(word);
        wait_cycles = 0;
    endtask

    task automatic note_error();
        error_count++;
        test_errors++;
    endtask

    // Store strobe lasts one cycle, sampled mid-cycle
    always @(negedge clk) begin : compare
        logic [`VEC_DATA_W-1:0] expected;
        if (rst_n && store_valid) begin
            wait_cycles = 0;
            if (exp_q.size() == 0) begin
                $display("%0t: store output seen while no store was pending", $time);
                note_error();
            end else begin
                expected = exp_q.pop_front();
                check_count++;
                test_checks++;
                if (store_data !== expected) begin
                    $display("** Error %0t: store_data got %h expected %h",
                             $time, store_data, expected);
                    note_error();
                end
            end
        end else if (exp_q.size() != 0) begin
            // Store is due in the cycle after its strobe
            wait_cycles++;
            if (wait_cycles > 1) begin
                $display("%0t: store output missing in the cycle after its strobe", $time);
                note_error();
                expected    = exp_q.pop_front();
                wait_cycles = 0;
            end
        end
    end

    task automatic end_test(input string name);
        if (exp_q.size() != 0) begin
            $display("%0t: %0d expected stores never appeared in %s",
                     $time, exp_q.size(), name);
            note_error();
            exp_q.delete();
        end
        wait_cycles = 0;
        test_count++;
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic report_totals();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    endtask

endmodule

`default_nettype wire

// File: sim/tb_vec_core.sv
// ------------------------------------------------------------------------
// Vector core testbench
// Drives loads and operations, keeps a shadow register file as reference
// ------------------------------------------------------------------------

`default_nettype none

`include "vec_settings.svh"

module tb_vec_core
    import vec_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED   = 32'hca35_bfc8;
    localparam int          N_MASK = 24;
    localparam int          N_ADD8 = 8;
    localparam int          N_ALU  = 32;
    localparam int          N_PAIR = 8;
    // Strobes issued over all tests
    localparam int NUM_STROBES = 2 * `VEC_NUM_REGS + 2 * N_MASK + 4 * N_ADD8
                                 + 2 * N_ALU + 4 * N_PAIR;
    localparam int TIMEOUT     = 8 * NUM_STROBES + 200;

    logic                      clk;
    logic                      rst_n;
    logic                      load_valid;
    logic [`VEC_ADDR_W-1:0]    load_addr;
    vec_data_t                 load_data;
    logic [`VEC_NUM_BYTES-1:0] load_mask;
    logic                      op_valid;
    vec_op_t                   op_code;
    logic [`VEC_ADDR_W-1:0]    op_vd;
    logic [`VEC_ADDR_W-1:0]    op_vs1;
    logic [`VEC_ADDR_W-1:0]    op_vs2;
    logic                      store_valid;
    vec_data_t                 store_data;

    logic [`VEC_DATA_W-1:0]    shadow [`VEC_NUM_REGS];
    vec_op_t                   alu_ops [5] = '{ADD8, ADD32, SUB32, AND, XOR};
    int                        cycle_count;

    vec_core_top u_dut (.*);
    vec_checker  u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [`VEC_DATA_W-1:0] rand_word();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // Expected word from the shadow, each lane wraps on its own
    function automatic logic [`VEC_DATA_W-1:0] ref_exec(input vec_op_t op,
            input logic [`VEC_ADDR_W-1:0] vs1, input logic [`VEC_ADDR_W-1:0] vs2);
        logic [`VEC_DATA_W-1:0] a;
        logic [`VEC_DATA_W-1:0] b;
        logic [`VEC_DATA_W-1:0] res;
        a = shadow[vs1];
        b = shadow[vs2];
        case (op)
            ADD8: begin
                for (int i = 0; i < `VEC_NUM_BYTES; i++)
                    res[8*i +: 8] = a[8*i +: 8] + b[8*i +: 8];
            end
            ADD32: begin
                for (int i = 0; i < `VEC_NUM_WORDS; i++)
                    res[32*i +: 32] = a[32*i +: 32] + b[32*i +: 32];
            end
            SUB32: begin
                for (int i = 0; i < `VEC_NUM_WORDS; i++)
                    res[32*i +: 32] = a[32*i +: 32] - b[32*i +: 32];
            end
            AND:     res = a & b;
            XOR:     res = a ^ b;
            // STORE returns vs1 unchanged
            default: res = a;
        endcase
        return res;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // One strobe cycle, then three idle cycles
    task automatic close_slot();
        next_cycle();
        load_valid = 1'b0;
        op_valid   = 1'b0;
        repeat (3) next_cycle();
    endtask

    task automatic drive_load(input logic [`VEC_ADDR_W-1:0] addr,
            input logic [`VEC_DATA_W-1:0] data, input logic [`VEC_NUM_BYTES-1:0] mask);
        load_valid = 1'b1;
        load_addr  = addr;
        load_data  = data;
        load_mask  = mask;
        for (int i = 0; i < `VEC_NUM_BYTES; i++) begin
            if (mask[i]) begin
                shadow[addr][8*i +: 8] = data[8*i +: 8];
            end
        end
    endtask

    task automatic drive_op(input vec_op_t op, input logic [`VEC_ADDR_W-1:0] vd,
            input logic [`VEC_ADDR_W-1:0] vs1, input logic [`VEC_ADDR_W-1:0] vs2);
        logic [`VEC_DATA_W-1:0] expected;
        expected = ref_exec(op, vs1, vs2);
        op_valid = 1'b1;
        op_code  = op;
        op_vd    = vd;
        op_vs1   = vs1;
        op_vs2   = vs2;
        if (op == STORE) begin
            u_chk.push_expected(expected);
        end else begin
            shadow[vd] = expected;
        end
    endtask

    task automatic load_reg(input logic [`VEC_ADDR_W-1:0] addr,
            input logic [`VEC_DATA_W-1:0] data, input logic [`VEC_NUM_BYTES-1:0] mask);
        drive_load(addr, data, mask);
        close_slot();
    endtask

    task automatic exec_op(input vec_op_t op, input logic [`VEC_ADDR_W-1:0] vd,
            input logic [`VEC_ADDR_W-1:0] vs1, input logic [`VEC_ADDR_W-1:0] vs2);
        drive_op(op, vd, vs1, vs2);
        close_slot();
    endtask

    initial begin : main
        logic [31:0]            rnd;
        logic [`VEC_ADDR_W-1:0] va;
        logic [`VEC_ADDR_W-1:0] vb;
        logic [`VEC_ADDR_W-1:0] vd;
        void'($urandom(SEED));
        rst_n      = 1'b0;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        load_mask  = '0;
        op_valid   = 1'b0;
        op_code    = ADD8;
        op_vd      = '0;
        op_vs1     = '0;
        op_vs2     = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();

        for (int r = 0; r < `VEC_NUM_REGS; r++) begin
            load_reg(r[`VEC_ADDR_W-1:0], rand_word(), '1);
            exec_op(STORE, '0, r[`VEC_ADDR_W-1:0], '0);
        end
        u_chk.end_test("full_load");

        // Every sixth mask is empty
        for (int i = 0; i < N_MASK; i++) begin
            rnd = $urandom();
            load_reg(rnd[4:0], rand_word(), (i % 6 == 0) ? 16'h0000 : rnd[31:16]);
            exec_op(STORE, '0, rnd[4:0], '0);
        end
        u_chk.end_test("masked_load");

        // Top bit set in every byte, so every lane carries out
        for (int i = 0; i < N_ADD8; i++) begin
            rnd = $urandom();
            va  = rnd[4:0];
            vb  = rnd[9:5];
            vd  = rnd[14:10];
            load_reg(va, rand_word() | {`VEC_NUM_BYTES{8'h80}}, '1);
            load_reg(vb, rand_word() | {`VEC_NUM_BYTES{8'h80}}, '1);
            exec_op(ADD8, vd, va, vb);
            exec_op(STORE, '0, vd, '0);
        end
        u_chk.end_test("add8_wrap");

        for (int i = 0; i < N_ALU; i++) begin
            rnd = $urandom();
            va  = rnd[4:0];
            vb  = rnd[9:5];
            vd  = (i % 5 == 2) ? va : rnd[14:10];
            exec_op(alu_ops[1 + i % 4], vd, va, vb);
            exec_op(STORE, '0, vd, '0);
        end
        u_chk.end_test("alu_random");

        // Load and operation on the same edge, both requests in one cycle
        for (int i = 0; i < N_PAIR; i++) begin
            rnd = $urandom();
            va  = {2'b01, rnd[2:0]};
            vb  = {2'b10, rnd[5:3]};
            vd  = {2'b11, rnd[8:6]};
            drive_op(alu_ops[i % 5], vd, va, vb);
            drive_load({2'b00, rnd[11:9]}, rand_word(), rnd[31:16] | 16'h0001);
            close_slot();
            exec_op(STORE, '0, {2'b00, rnd[11:9]}, '0);
            exec_op(STORE, '0, vd, '0);
        end
        u_chk.end_test("dual_request");

        u_chk.report_totals();
        if (u_chk.error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+source
source/vec_pkg.sv
source/vec_rf.sv
source/vec_exec_unit.sv
source/vec_load_unit.sv
source/vec_wr_arbiter.sv
source/vec_core_top.sv
sim/vec_checker.sv
sim/tb_vec_core.sv
